/* sim.f */
+incdir+test
verilog/imuldiv_pkg.sv
verilog/int_div_dpath.sv
verilog/int_div_ctrl.sv
verilog/int_mul_iterative.sv
verilog/imuldiv_unit.sv
test/imuldiv_tb.sv

/* test/imuldiv_model.svh */
// ----------------------------------------------------------
// reference model for product, quotient and remainder
// ----------------------------------------------------------

`ifndef IMULDIV_MODEL_SVH
`define IMULDIV_MODEL_SVH

// full 64-bit signed product
function automatic logic [63:0] model_product(input logic [31:0] a, input logic [31:0] b);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  sa = {{32{a[31]}}, a};
  sb = {{32{b[31]}}, b};
  return sa * sb;
endfunction

// quotient, truncated toward zero when signed
function automatic logic [31:0] model_quotient(input logic [31:0] a, input logic [31:0] b,
                                               input logic is_signed);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  logic signed [63:0] q;
  // 64-bit math so that most negative over minus one wraps cleanly
  sa = is_signed ? {{32{a[31]}}, a} : {32'd0, a};
  sb = is_signed ? {{32{b[31]}}, b} : {32'd0, b};
  q = sa / sb;
  return q[31:0];
endfunction

// remainder, sign of the dividend when signed
function automatic logic [31:0] model_remainder(input logic [31:0] a, input logic [31:0] b,
                                                input logic is_signed);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  logic signed [63:0] r;
  sa = is_signed ? {{32{a[31]}}, a} : {32'd0, a};
  sb = is_signed ? {{32{b[31]}}, b} : {32'd0, b};
  r = sa % sb;
  return r[31:0];
endfunction

// packed divide reply, remainder on top
function automatic logic [63:0] model_divide(input logic [31:0] a, input logic [31:0] b,
                                             input logic is_signed);
  return {model_remainder(a, b, is_signed), model_quotient(a, b, is_signed)};
endfunction

`endif

/* test/imuldiv_tb.sv */
// ----------------------------------------------------------
// testbench for the multiply/divide unit, random requests
// with reply back-pressure, checked against a reference model
// ----------------------------------------------------------

`timescale 1ns/1ps

module imuldiv_tb import imuldiv_pkg::*; ();

  localparam int NUM_REQS   = 300;
  localparam int WAIT_LIMIT = 200;

  `include "imuldiv_model.svh"

  logic       clk;
  logic       reset;
  logic       req_val;
  logic       req_rdy;
  muldiv_fn_t req_fn;
  operand_t   req_a;
  operand_t   req_b;
  logic       resp_val;
  logic       resp_rdy;
  result_t    resp_result;

  int value_errors;
  int proto_errors;
  int timeouts;

  // expected replies in issue order
  result_t exp_q[$];

  // reply held back at the previous edge
  logic    stalled;
  result_t stalled_result;

  imuldiv_unit #(.ORDER_DEPTH(2)) dut (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------

  // half the picks land on an edge value
  function automatic operand_t pick_operand();
    int unsigned sel;
    sel = $urandom_range(9);
    case (sel)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hffff_ffff;
      3:       return 32'h8000_0000;
      4:       return 32'h7fff_ffff;
      default: return $urandom();
    endcase
  endfunction

  // zero divisors are never issued
  function automatic operand_t pick_divisor();
    operand_t v;
    v = pick_operand();
    while (v == 32'd0) begin
      v = pick_operand();
    end
    return v;
  endfunction

  function automatic result_t expected_result(input muldiv_fn_t fn, input operand_t a,
                                              input operand_t b);
    case (fn)
      fn_div:  return model_divide(a, b, 1'b1);
      fn_divu: return model_divide(a, b, 1'b0);
      default: return model_product(a, b);
    endcase
  endfunction

  // hold val and data until the DUT takes the request
  task automatic send_request(input muldiv_fn_t fn, input operand_t a, input operand_t b,
                              output bit timed_out);
    int waited;
    waited    = 0;
    timed_out = 1'b0;
    req_val <= 1'b1;
    req_fn  <= fn;
    req_a   <= a;
    req_b   <= b;
    @(posedge clk);
    while (!req_rdy && !timed_out) begin
      waited++;
      if (waited >= WAIT_LIMIT) begin
        timed_out = 1'b1;
        timeouts++;
        $display("timeout: request was not accepted within %0d cycles", WAIT_LIMIT);
      end else begin
        @(posedge clk);
      end
    end
    req_val <= 1'b0;
  endtask

  // ----------------------------------------------------------
  // reply side, random back-pressure and scoreboard
  // ----------------------------------------------------------

  // ready about 70 percent of the cycles
  always @(posedge clk) begin
    if (reset) begin
      resp_rdy <= 1'b0;
    end else begin
      resp_rdy <= ($urandom_range(99) >= 30);
    end
  end

  always @(posedge clk) begin
    result_t exp;
    if (reset) begin
      stalled = 1'b0;
    end else begin
      // a stalled reply keeps val and data until it transfers
      if (stalled && resp_val !== 1'b1) begin
        value_errors++;
        $display("error resp_val: expected %h, got %h under back-pressure", 1'b1, resp_val);
      end
      if (stalled && resp_result !== stalled_result) begin
        value_errors++;
        $display("error resp_result: expected %h, got %h under back-pressure",
                 stalled_result, resp_result);
      end
      if (resp_val && exp_q.size() == 0) begin
        proto_errors++;
        if (resp_rdy) begin
          $display("unexpected reply taken while no request was outstanding");
        end else begin
          $display("resp_val went high while no request was outstanding");
        end
      end else if (resp_val && resp_rdy) begin
        // replies must come back in issue order
        exp = exp_q.pop_front();
        if (resp_result !== exp) begin
          value_errors++;
          $display("error resp_result: expected %h, got %h", exp, resp_result);
        end
      end
      if (req_val && req_rdy) begin
        exp_q.push_back(expected_result(req_fn, req_a, req_b));
      end
      stalled        = resp_val && !resp_rdy;
      stalled_result = resp_result;
    end
  end

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial begin
    muldiv_fn_t fn;
    operand_t   a;
    operand_t   b;
    bit         timed_out;
    int         waited;
    void'($urandom(32'h6d23_b1f3));
    value_errors = 0;
    proto_errors = 0;
    timeouts     = 0;
    timed_out    = 1'b0;
    stalled      = 1'b0;
    reset        = 1'b1;
    req_val      = 1'b0;
    req_fn       = fn_mul;
    req_a        = '0;
    req_b        = '0;
    resp_rdy     = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    // idle after reset
    if (resp_val !== 1'b0) begin
      value_errors++;
      $display("error resp_val: expected %h, got %h after reset", 1'b0, resp_val);
    end
    if (req_rdy !== 1'b1) begin
      value_errors++;
      $display("error req_rdy: expected %h, got %h after reset", 1'b1, req_rdy);
    end

    for (int i = 0; i < NUM_REQS && !timed_out; i++) begin
      // a few corner cases first, then random traffic
      case (i)
        0: begin fn = fn_div;  a = 32'h8000_0000; b = 32'hffff_ffff; end
        1: begin fn = fn_mul;  a = 32'h8000_0000; b = 32'h8000_0000; end
        2: begin fn = fn_divu; a = 32'hffff_ffff; b = 32'h8000_0001; end
        3: begin fn = fn_mul;  a = 32'hffff_ffff; b = 32'h7fff_ffff; end
        default: begin
          fn = muldiv_fn_t'($urandom_range(3));
          a  = pick_operand();
          b  = (fn == fn_div || fn == fn_divu) ? pick_divisor() : pick_operand();
        end
      endcase
      send_request(fn, a, b, timed_out);
      repeat ($urandom_range(3)) @(posedge clk);
    end

    // let the last replies drain
    waited = 0;
    while (!timed_out && exp_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited >= WAIT_LIMIT) begin
        timed_out = 1'b1;
        timeouts++;
        $display("timeout: %0d replies still outstanding after %0d cycles",
                 exp_q.size(), WAIT_LIMIT);
      end
    end
    repeat (2) @(posedge clk);

    $display("summary: %0d value errors, %0d protocol errors, %0d timeouts",
             value_errors, proto_errors, timeouts);
    if (value_errors == 0 && proto_errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog/imuldiv_pkg.sv */
// ----------------------------------------------------------
// shared types for the iterative multiply/divide unit
// ----------------------------------------------------------

package imuldiv_pkg;

  // one machine word
  typedef logic [31:0] operand_t;

  // two words, for divide the remainder is on top and the quotient below
  typedef logic [63:0] result_t;

  // function code of a request
  typedef logic [1:0] muldiv_fn_t;

  localparam muldiv_fn_t fn_mul  = 2'd0;
  localparam muldiv_fn_t fn_div  = 2'd1;
  localparam muldiv_fn_t fn_divu = 2'd2;
  // code 3 is decoded as a multiply

  // loop step counter, 32 steps per operation
  typedef logic [4:0] step_count_t;

  localparam step_count_t step_last = 5'd31;

  // iterative unit FSM
  typedef enum logic [1:0] {
    idle = 2'd0,
    calc = 2'd1,
    done = 2'd2
  } div_state_t;

endpackage

/* verilog/imuldiv_unit.sv */
// ----------------------------------------------------------
// multiply/divide top, steers requests by function code
// and returns replies in request order
// ----------------------------------------------------------

`timescale 1ns/1ps

module imuldiv_unit import imuldiv_pkg::*; #(
  parameter int ORDER_DEPTH = 2
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       req_val,
  output logic       req_rdy,
  input  muldiv_fn_t req_fn,
  input  operand_t   req_a,
  input  operand_t   req_b,
  output logic       resp_val,
  input  logic       resp_rdy,
  output result_t    resp_result
);

  localparam int PTR_W = $clog2(ORDER_DEPTH);
  localparam int CNT_W = $clog2(ORDER_DEPTH + 1);

  // ----------------------------------------------------------
  // request dispatch
  // ----------------------------------------------------------

  logic is_div;
  logic signed_op;
  logic q_full;
  logic q_empty;

  logic mul_req_val;
  logic mul_req_rdy;
  logic mul_resp_val;
  logic mul_resp_rdy;
  result_t mul_result;

  logic div_req_val;
  logic div_req_rdy;
  logic div_resp_val;
  logic div_resp_rdy;
  logic div_load_en;
  logic div_step_en;
  result_t div_result;

  // any code that is not a divide goes to the multiplier
  assign is_div    = (req_fn == fn_div) || (req_fn == fn_divu);
  assign signed_op = (req_fn == fn_div);

  // a unit only sees val when its reply has a slot in the order queue
  assign mul_req_val = req_val && !is_div && !q_full;
  assign div_req_val = req_val && is_div && !q_full;

  assign req_rdy = (is_div ? div_req_rdy : mul_req_rdy) && !q_full;

  int_mul_iterative mul (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .a        (req_a),
    .b        (req_b),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .result   (mul_result)
  );

  int_div_ctrl div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .load_en  (div_load_en),
    .step_en  (div_step_en)
  );

  int_div_dpath div_dpath (
    .clk       (clk),
    .reset     (reset),
    .load_en   (div_load_en),
    .step_en   (div_step_en),
    .signed_op (signed_op),
    .a         (req_a),
    .b         (req_b),
    .result    (div_result)
  );

  // ----------------------------------------------------------
  // order queue, one bit per pending reply, set for divide
  // ----------------------------------------------------------

  logic [ORDER_DEPTH-1:0] order_q;
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [CNT_W-1:0]       q_count;
  logic                   head_div;
  logic                   push;
  logic                   pop;

  assign q_full  = (q_count == CNT_W'(ORDER_DEPTH));
  assign q_empty = (q_count == '0);
  assign head_div = order_q[rd_ptr];

  assign push = req_val && req_rdy;
  assign pop  = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (push) begin
      order_q[wr_ptr] <= is_div;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(ORDER_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(ORDER_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      // push never happens when full, pop never when empty
      case ({push, pop})
        2'b10:   q_count <= q_count + CNT_W'(1);
        2'b01:   q_count <= q_count - CNT_W'(1);
        default: q_count <= q_count;
      endcase
    end
  end

  // ----------------------------------------------------------
  // reply merge, only the head unit sees resp_rdy
  // ----------------------------------------------------------

  assign resp_val     = !q_empty && (head_div ? div_resp_val : mul_resp_val);
  assign resp_result  = head_div ? div_result : mul_result;
  assign mul_resp_rdy = resp_rdy && !q_empty && !head_div;
  assign div_resp_rdy = resp_rdy && !q_empty && head_div;

endmodule

/* verilog/int_div_ctrl.sv */
// ----------------------------------------------------------
// divider control, idle/calc/done FSM with step counter
// ----------------------------------------------------------

`timescale 1ns/1ps

module int_div_ctrl import imuldiv_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load_en,
  output logic step_en
);

  div_state_t  state;
  step_count_t count;

  // set after the last of the 32 steps, gives one settle cycle in calc
  logic        last_step;

  logic        req_go;
  logic        resp_go;

  // handshake flags come straight from the state
  assign req_rdy  = (state == idle);
  assign resp_val = (state == done);

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // operands are captured on the accepting edge
  assign load_en = req_go;

  // one datapath step per calc cycle until the count runs out
  assign step_en = (state == calc) && !last_step;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      count     <= '0;
      last_step <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (req_go) begin
            state     <= calc;
            count     <= '0;
            last_step <= 1'b0;
          end
        end
        calc: begin
          if (last_step) begin
            state     <= done;
            last_step <= 1'b0;
          end else begin
            // count wraps back to zero on the last step
            count <= count + step_count_t'(1);
            if (count == step_last) begin
              last_step <= 1'b1;
            end
          end
        end
        done: begin
          // hold the reply under back-pressure
          if (resp_go) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

endmodule

/* verilog/int_div_dpath.sv */
// ----------------------------------------------------------
// divider datapath, restoring shift-subtract on magnitudes
// with sign fix-up of quotient and remainder at the output
// ----------------------------------------------------------

`timescale 1ns/1ps

module int_div_dpath import imuldiv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     load_en,
  input  logic     step_en,
  input  logic     signed_op,
  input  operand_t a,
  input  operand_t b,
  output result_t  result
);

  // ----------------------------------------------------------
  // operand magnitudes
  // ----------------------------------------------------------

  // sign bits only count for a signed request
  logic     a_sign;
  logic     b_sign;
  operand_t a_mag;
  operand_t b_mag;

  assign a_sign = signed_op && a[31];
  assign b_sign = signed_op && b[31];

  // two's complement negate, the most negative value maps onto itself
  // which is its correct unsigned magnitude
  assign a_mag = a_sign ? (~a + 32'd1) : a;
  assign b_mag = b_sign ? (~b + 32'd1) : b;

  // ----------------------------------------------------------
  // state registers
  // ----------------------------------------------------------

  // stored sign flags of dividend and divisor
  logic        a_neg;
  logic        b_neg;

  // partial remainder on top, dividend bits shifting into quotient below
  logic [64:0] rq_reg;

  // divisor magnitude lined up with the remainder half
  logic [64:0] div_reg;

  // one restoring step
  logic [64:0] rq_shift;
  logic [64:0] rq_diff;
  logic [64:0] rq_next;

  assign rq_shift = rq_reg << 1;
  assign rq_diff  = rq_shift - div_reg;

  // top bit set means the divisor did not fit, so keep the shifted value
  // and leave a zero quotient bit, else keep the difference with a one
  assign rq_next = rq_diff[64] ? {rq_shift[64:1], 1'b0} : {rq_diff[64:1], 1'b1};

  always_ff @(posedge clk) begin
    if (reset) begin
      a_neg <= 1'b0;
      b_neg <= 1'b0;
    end else if (load_en) begin
      a_neg <= a_sign;
      b_neg <= b_sign;
    end
  end

  always_ff @(posedge clk) begin
    if (load_en) begin
      rq_reg  <= {33'd0, a_mag};
      div_reg <= {1'b0, b_mag, 32'd0};
    end else if (step_en) begin
      rq_reg  <= rq_next;
    end
  end

  // ----------------------------------------------------------
  // sign correction
  // ----------------------------------------------------------

  operand_t quot_mag;
  operand_t rem_mag;
  operand_t quot;
  operand_t rem;

  // after 32 steps the remainder sits just above the quotient
  assign quot_mag = rq_reg[31:0];
  assign rem_mag  = rq_reg[63:32];

  // quotient negative when exactly one operand was negative
  assign quot = (a_neg ^ b_neg) ? (~quot_mag + 32'd1) : quot_mag;

  // remainder follows the dividend
  assign rem = a_neg ? (~rem_mag + 32'd1) : rem_mag;

  assign result = {rem, quot};

endmodule

/* verilog/int_mul_iterative.sv */
// ----------------------------------------------------------
// iterative signed multiplier, shift-add on magnitudes
// with its own idle/calc/done control
// ----------------------------------------------------------

`timescale 1ns/1ps

module int_mul_iterative import imuldiv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     req_val,
  output logic     req_rdy,
  input  operand_t a,
  input  operand_t b,
  output logic     resp_val,
  input  logic     resp_rdy,
  output result_t  result
);

  // ----------------------------------------------------------
  // control
  // ----------------------------------------------------------

  div_state_t  state;
  step_count_t count;

  // marks the settle cycle after the last step
  logic        last_step;

  logic        req_go;
  logic        resp_go;
  logic        step_en;

  assign req_rdy  = (state == idle);
  assign resp_val = (state == done);

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;
  assign step_en = (state == calc) && !last_step;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      count     <= '0;
      last_step <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (req_go) begin
            state     <= calc;
            count     <= '0;
            last_step <= 1'b0;
          end
        end
        calc: begin
          if (last_step) begin
            state     <= done;
            last_step <= 1'b0;
          end else begin
            count <= count + step_count_t'(1);
            if (count == step_last) begin
              last_step <= 1'b1;
            end
          end
        end
        done: begin
          if (resp_go) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // datapath
  // ----------------------------------------------------------

  operand_t a_mag;
  operand_t b_mag;

  // multiply is always signed
  assign a_mag = a[31] ? (~a + 32'd1) : a;
  assign b_mag = b[31] ? (~b + 32'd1) : b;

  // product magnitude builds up here
  result_t  acc_reg;
  // multiplicand moves one place left per step
  result_t  mcand_reg;
  // multiplier moves right, its low bit picks the add
  operand_t mplier_reg;
  // product sign
  logic     neg_reg;

  always_ff @(posedge clk) begin
    if (req_go) begin
      acc_reg    <= '0;
      mcand_reg  <= {32'd0, a_mag};
      mplier_reg <= b_mag;
      neg_reg    <= a[31] ^ b[31];
    end else if (step_en) begin
      if (mplier_reg[0]) begin
        acc_reg <= acc_reg + mcand_reg;
      end
      mcand_reg  <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  // negate at the output, no extra cycle
  assign result = neg_reg ? (~acc_reg + 64'd1) : acc_reg;

endmodule
